//--- project.f
source/cic_pkg.sv
source/cic_integrator.sv
source/comb_ram.sv
source/cic_comb_seq.sv
source/credit_fifo.sv
source/cic_decim_top.sv
tests/cic_decim_chk.sv
tests/cic_decim_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cic decimator testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module cic_decim_tb -f project.f -o cic_decim_sim

./obj_dir/cic_decim_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Test completed successfully" sim.log
then
	echo "simulation passed"
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- source/cic_comb_seq.sv
// ------------------------------
// sequential cic comb engine
// one subtractor walks all comb stages,
// i then q, and rounds the result
// ------------------------------

module cic_comb_seq #(
	parameter int STAGES = 3,
	parameter int ACC_W = 25
) (
	input  logic                    clock,
	input  logic                    rst_i,
	input  logic                    integ_strobe_i,
	input  logic signed [ACC_W-1:0] integ_i_i,
	input  logic signed [ACC_W-1:0] integ_q_i,
	output logic                    samp_valid_o,
	output cic_pkg::cic_sample_t    samp_o
);

	localparam int SB = cic_pkg::stage_bits(STAGES);
	localparam int AB = 3 + SB;
	localparam int RAM_W = cic_pkg::ACC_MAX_WIDTH;
	localparam int OUT_W = cic_pkg::OUT_WIDTH;

	// stage index values
	localparam logic [SB-1:0] LOAD_STAGE = '0;
	localparam logic [SB-1:0] LAST_STAGE = SB'(STAGES);
	localparam logic [SB-1:0] SETTLE_STAGE = SB'(STAGES + 1);
	localparam logic [SB-1:0] OUT_STAGE = SB'(STAGES + 2);

	// comb/prev select in the address
	localparam logic SEL_COMB = 1'b0;
	localparam logic SEL_PREV = 1'b1;

	// sequencer state
	logic [SB-1:0] stage;
	logic [1:0]    phase;
	logic          q;
	logic          ping_pong;
	logic          primed;
	logic          active;
	logic          rbank;
	logic          wbank;

	// datapath
	logic signed [ACC_W-1:0] q_hold;
	logic signed [ACC_W-1:0] t;
	logic signed [ACC_W-1:0] x_sel;
	logic signed [ACC_W-1:0] rdata_acc;
	logic signed [ACC_W-1:0] prev_term;
	logic signed [ACC_W-1:0] diff;
	logic signed [ACC_W-1:0] wval;
	logic signed [OUT_W-1:0] rounded;

	// ram ports
	logic             wen;
	logic [AB-1:0]    waddr;
	logic [AB-1:0]    raddr;
	logic [RAM_W-1:0] ram_rdata;

	// prev read from last pass's bank, everything else in the current one
	assign rbank = ping_pong;
	assign wbank = ~ping_pong;

	// q pass starts by itself once i is done
	assign active = q || integ_strobe_i;
	assign x_sel = q ? q_hold : integ_i_i;

	assign rdata_acc = ram_rdata[ACC_W-1:0];
	// first pass after reset has no valid prev terms
	assign prev_term = primed ? rdata_acc : '0;
	// shared subtractor, comb[k] = comb[k-1] - prev[k]
	assign diff = t - prev_term;

	// top OUT_W bits plus the bit below, half-up
	assign rounded = rdata_acc[ACC_W-1 -: OUT_W] + OUT_W'(rdata_acc[ACC_W-1-OUT_W]);

	// ------------------------------
	// address decoder
	// ------------------------------

	always_comb
	begin
		wen = 1'b0;
		waddr = {q, wbank, SEL_COMB, stage};
		wval = x_sel;
		raddr = {q, wbank, SEL_COMB, stage};
		if (stage == LOAD_STAGE)
		begin
			// comb[0] = integrator output
			wen = active;
		end
		else if (stage <= LAST_STAGE)
		begin
			case (phase)
				2'd0:
				begin
					// fetch comb[k-1], retire prev[k-1] from the last stage
					raddr = {q, wbank, SEL_COMB, stage - 1'b1};
					if (stage != SB'(1))
					begin
						wen = 1'b1;
						waddr = {q, wbank, SEL_PREV, stage - 1'b1};
						wval = t;
					end
				end
				2'd1:
				begin
					// fetch prev[k]
					raddr = {q, rbank, SEL_PREV, stage};
				end
				default:
				begin
					wen = 1'b1;
					wval = diff;
				end
			endcase
		end
		else if (stage == SETTLE_STAGE)
		begin
			// last prev write, fetch final comb
			wen = 1'b1;
			waddr = {q, wbank, SEL_PREV, LAST_STAGE};
			wval = t;
			raddr = {q, wbank, SEL_COMB, LAST_STAGE};
		end
	end

	comb_ram #(
		.ADDR_BITS(AB),
		.DATA_BITS(RAM_W)
	) i_comb_ram (
		.clock(clock),
		.wen_i(wen),
		.waddr_i(waddr),
		.wdata_i(RAM_W'(wval)),
		.raddr_i(raddr),
		.rdata_o(ram_rdata)
	);

	// ------------------------------
	// sequencer
	// ------------------------------

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			stage <= LOAD_STAGE;
			phase <= 2'd0;
			q <= 1'b0;
			ping_pong <= 1'b0;
			primed <= 1'b0;
			samp_valid_o <= 1'b0;
		end
		else
		begin
			samp_valid_o <= 1'b0;
			if (stage == LOAD_STAGE)
			begin
				if (active)
				begin
					stage <= stage + 1'b1;
					phase <= 2'd0;
				end
			end
			else if (stage <= LAST_STAGE)
			begin
				if (phase == 2'd2)
				begin
					phase <= 2'd0;
					stage <= stage + 1'b1;
				end
				else
				begin
					phase <= phase + 1'b1;
				end
			end
			else if (stage == SETTLE_STAGE)
			begin
				stage <= stage + 1'b1;
			end
			else
			begin
				// output cycle, then i -> q or q -> idle
				samp_valid_o <= 1'b1;
				stage <= LOAD_STAGE;
				q <= ~q;
				if (q)
				begin
					ping_pong <= ~ping_pong;
					primed <= 1'b1;
				end
			end
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if (stage == LOAD_STAGE && integ_strobe_i && !q)
		begin
			q_hold <= integ_q_i;
		end
		if (stage != LOAD_STAGE && stage <= LAST_STAGE && phase == 2'd1)
		begin
			t <= rdata_acc;
		end
		if (stage == OUT_STAGE)
		begin
			samp_o.data <= rounded;
			samp_o.is_q <= q;
		end
	end

endmodule

//--- source/cic_decim_top.sv
// ------------------------------
// cic i/q decimator top
// integrators, comb engine, output fifo
// ------------------------------

module cic_decim_top #(
	parameter int STAGES = 3,
	parameter int DECIMATION = 8,
	parameter int IN_WIDTH = 16,
	parameter int FIFO_DEPTH = 4,
	parameter int CREDITS = 2
) (
	input  logic                       clock,
	input  logic                       rst_i,
	input  logic                       in_strobe_i,
	input  logic signed [IN_WIDTH-1:0] in_i_i,
	input  logic signed [IN_WIDTH-1:0] in_q_i,
	input  logic                       credit_i,
	output logic                       out_valid_o,
	output cic_pkg::cic_sample_t       out_sample_o,
	output logic                       overflow_o
);

	localparam int ACC_W = cic_pkg::acc_width(IN_WIDTH, STAGES, DECIMATION);

	// integrator to comb engine
	logic                    integ_strobe;
	logic signed [ACC_W-1:0] integ_i;
	logic signed [ACC_W-1:0] integ_q;

	// comb engine to fifo
	logic                 samp_valid;
	cic_pkg::cic_sample_t samp;

	cic_integrator #(
		.STAGES(STAGES),
		.DECIMATION(DECIMATION),
		.IN_WIDTH(IN_WIDTH)
	) i_cic_integrator (
		.clock(clock),
		.rst_i(rst_i),
		.in_strobe_i(in_strobe_i),
		.in_i_i(in_i_i),
		.in_q_i(in_q_i),
		.integ_strobe_o(integ_strobe),
		.integ_i_o(integ_i),
		.integ_q_o(integ_q)
	);

	cic_comb_seq #(
		.STAGES(STAGES),
		.ACC_W(ACC_W)
	) i_cic_comb_seq (
		.clock(clock),
		.rst_i(rst_i),
		.integ_strobe_i(integ_strobe),
		.integ_i_i(integ_i),
		.integ_q_i(integ_q),
		.samp_valid_o(samp_valid),
		.samp_o(samp)
	);

	credit_fifo #(
		.T(cic_pkg::cic_sample_t),
		.DEPTH(FIFO_DEPTH),
		.CREDITS(CREDITS)
	) i_credit_fifo (
		.clock(clock),
		.rst_i(rst_i),
		.push_i(samp_valid),
		.push_data_i(samp),
		.credit_i(credit_i),
		.out_valid_o(out_valid_o),
		.out_data_o(out_sample_o),
		.overflow_o(overflow_o)
	);

endmodule

//--- source/cic_integrator.sv
// ------------------------------
// cic integrator
// input rate i/q integrator chains and
// decimation counter
// ------------------------------

module cic_integrator #(
	parameter int STAGES = 3,
	parameter int DECIMATION = 8,
	parameter int IN_WIDTH = 16,
	localparam int ACC_W = cic_pkg::acc_width(IN_WIDTH, STAGES, DECIMATION)
) (
	input  logic                    clock,
	input  logic                    rst_i,
	input  logic                    in_strobe_i,
	input  logic signed [IN_WIDTH-1:0] in_i_i,
	input  logic signed [IN_WIDTH-1:0] in_q_i,
	output logic                    integ_strobe_o,
	output logic signed [ACC_W-1:0] integ_i_o,
	output logic signed [ACC_W-1:0] integ_q_o
);

	localparam int CNT_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;

	logic [CNT_W-1:0]        sample_cnt;
	logic                    last_sample;
	logic signed [ACC_W-1:0] acc_i [STAGES];
	logic signed [ACC_W-1:0] acc_q [STAGES];
	logic signed [ACC_W-1:0] sum_i [STAGES];
	logic signed [ACC_W-1:0] sum_q [STAGES];

	// decimation phase, last input of the block
	assign last_sample = (sample_cnt == CNT_W'(DECIMATION - 1));

	// next accumulator values, whole chain in one input period
	always_comb
	begin
		// sign-extended input into stage 0
		sum_i[0] = acc_i[0] + ACC_W'(in_i_i);
		sum_q[0] = acc_q[0] + ACC_W'(in_q_i);
		for (int k = 1; k < STAGES; k++)
		begin
			// wrapping adds, two's complement growth is harmless here
			sum_i[k] = acc_i[k] + sum_i[k-1];
			sum_q[k] = acc_q[k] + sum_q[k-1];
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			sample_cnt <= '0;
			integ_strobe_o <= 1'b0;
			for (int k = 0; k < STAGES; k++)
			begin
				acc_i[k] <= '0;
				acc_q[k] <= '0;
			end
		end
		else
		begin
			// one cycle pulse on the decimated sample
			integ_strobe_o <= in_strobe_i && last_sample;
			if (in_strobe_i)
			begin
				for (int k = 0; k < STAGES; k++)
				begin
					acc_i[k] <= sum_i[k];
					acc_q[k] <= sum_q[k];
				end
				sample_cnt <= last_sample ? '0 : sample_cnt + 1'b1;
			end
		end
	end

	// held for the comb engine until the next pulse
	always_ff @(posedge clock)
	begin
		if (in_strobe_i && last_sample)
		begin
			integ_i_o <= sum_i[STAGES-1];
			integ_q_o <= sum_q[STAGES-1];
		end
	end

endmodule

//--- source/cic_pkg.sv
// ------------------------------
// cic decimator shared package
// widths, output sample struct and
// width helpers for the i/q path
// ------------------------------

package cic_pkg;

	// ------------------------------
	// fixed widths
	// ------------------------------

	// ram data word, upper bound on accumulator growth
	localparam int ACC_MAX_WIDTH = 48;

	// output sample width, fixed by the struct below
	localparam int OUT_WIDTH = 16;

	// output link payload
	typedef struct packed {
		// rounded comb result
		logic signed [OUT_WIDTH-1:0] data;
		// set on the q half of a pair
		logic                        is_q;
	} cic_sample_t;

	// ------------------------------
	// width helpers
	// ------------------------------

	// full accumulator width, no pruning, differential delay 1
	function automatic int acc_width(input int in_width, input int stages,
		input int decimation);
		return in_width + stages * $clog2(decimation);
	endfunction

	// bits for stage index 0 .. stages+2
	// 0 loads comb[0], then stages, settle, output
	function automatic int stage_bits(input int stages);
		return $clog2(stages + 3);
	endfunction

endpackage

//--- source/comb_ram.sv
// ------------------------------
// comb term ram
// simple dual-port, registered read
// ------------------------------

module comb_ram #(
	parameter int ADDR_BITS = 6,
	parameter int DATA_BITS = 48
) (
	input  logic                 clock,
	input  logic                 wen_i,
	input  logic [ADDR_BITS-1:0] waddr_i,
	input  logic [DATA_BITS-1:0] wdata_i,
	input  logic [ADDR_BITS-1:0] raddr_i,
	output logic [DATA_BITS-1:0] rdata_o
);

	// address is {q, bank, comb/prev, stage}
	logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

	always_ff @(posedge clock)
	begin
		if (wen_i)
		begin
			mem[waddr_i] <= wdata_i;
		end
		// same-address collision returns old data
		rdata_o <= mem[raddr_i];
	end

endmodule

//--- source/credit_fifo.sv
// ------------------------------
// credit-based output fifo
// sends only while credits remain,
// drops on full with sticky overflow
// ------------------------------

module credit_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4,
	parameter int CREDITS = 2
) (
	input  logic clock,
	input  logic rst_i,
	input  logic push_i,
	input  T     push_data_i,
	input  logic credit_i,
	output logic out_valid_o,
	output T     out_data_o,
	output logic overflow_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(CREDITS + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             full;
	logic             accept;
	logic             send;

	// circular pointer step, any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign accept = push_i && !full;
	// one entry per cycle, needs data and a credit
	assign send = (count != '0) && (credits != '0);

	always_ff @(posedge clock)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(CREDITS);
			out_valid_o <= 1'b0;
			overflow_o <= 1'b0;
		end
		else
		begin
			out_valid_o <= send;
			if (accept)
				wr_ptr <= next_ptr(wr_ptr);
			if (send)
				rd_ptr <= next_ptr(rd_ptr);
			if (accept && !send)
				count <= count + 1'b1;
			else if (send && !accept)
				count <= count - 1'b1;
			// returned credit beyond the consumer buffer is ignored
			if (send && !credit_i)
				credits <= credits - 1'b1;
			else if (credit_i && !send && credits != CRD_W'(CREDITS))
				credits <= credits + 1'b1;
			// stream cannot stall, sample lost
			if (push_i && full)
				overflow_o <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			mem[wr_ptr] <= push_data_i;
		if (send)
			out_data_o <= mem[rd_ptr];
	end

endmodule

//--- tests/cic_decim_chk.sv
// ------------------------------
// output link checker
// valid and credit rules on the fifo
// ------------------------------

module cic_decim_chk #(
	parameter int CREDITS = 2,
	parameter int CRD_W = 2
) (
	input logic             clock,
	input logic             rst_i,
	input logic             out_valid_i,
	input logic [CRD_W-1:0] credits_i
);

	// failed assertion count, read by the testbench
	int fail_count = 0;

	// valid cleared by reset
	valid_after_reset: assert property (@(posedge clock) rst_i |=> !out_valid_i)
	else
	begin
		$error("out_valid_o high in the cycle after reset");
		fail_count++;
	end

	// no credit, nothing on the link next cycle
	send_needs_credit: assert property (@(posedge clock) disable iff (rst_i)
		(credits_i == '0) |=> !out_valid_i)
	else
	begin
		$error("send while the credit count is zero");
		fail_count++;
	end

	// bounded by the consumer buffer
	credit_bound: assert property (@(posedge clock) disable iff (rst_i)
		credits_i <= CRD_W'(CREDITS))
	else
	begin
		$error("credit count above the consumer buffer size");
		fail_count++;
	end

endmodule

//--- tests/cic_decim_tb.sv
// ------------------------------
// cic decimator testbench
// directed and random i/q stimulus,
// credit consumer, in-order compare
// ------------------------------

module cic_decim_tb;

	localparam int STAGES = 3;
	localparam int DECIMATION = 8;
	localparam int IN_WIDTH = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int CREDITS = 2;
	localparam int ACC_W = cic_pkg::acc_width(IN_WIDTH, STAGES, DECIMATION);
	localparam int OUT_W = cic_pkg::OUT_WIDTH;
	localparam logic [63:0] ACC_MASK = (64'd1 << ACC_W) - 64'd1;
	localparam logic [63:0] OUT_MASK = (64'd1 << OUT_W) - 64'd1;
	localparam int WAIT_LIMIT = 400;
	localparam logic signed [IN_WIDTH-1:0] FULL_SCALE = {1'b0, {(IN_WIDTH-1){1'b1}}};
	localparam logic signed [IN_WIDTH-1:0] STEP = IN_WIDTH'(1000);

	logic                       clock;
	logic                       rst_i = 1'b1;
	logic                       in_strobe_i = 1'b0;
	logic signed [IN_WIDTH-1:0] in_i_i = '0;
	logic signed [IN_WIDTH-1:0] in_q_i = '0;
	logic                       credit_i = 1'b0;
	logic                       out_valid_o;
	cic_pkg::cic_sample_t       out_sample_o;
	logic                       overflow_o;

	// reference model state, one row per channel
	cic_pkg::cic_sample_t exp_q[$];
	cic_pkg::cic_sample_t expected;
	logic [63:0] integ_st [2][STAGES];
	logic [63:0] prev_st [2][STAGES];
	int phase_cnt = 0;

	// control flags, changed on clock edges
	logic hold_credits = 1'b0;
	logic check_en = 1'b1;
	logic zero_i = 1'b0;
	logic signed [OUT_W-1:0] last_i = '0;
	int held_sends = 0;
	int owed = 0;
	int delay = 0;
	int data_errors = 0;
	int check_errors = 0;
	int timeouts = 0;
	int unsigned seed;

	cic_decim_top #(
		.STAGES(STAGES),
		.DECIMATION(DECIMATION),
		.IN_WIDTH(IN_WIDTH),
		.FIFO_DEPTH(FIFO_DEPTH),
		.CREDITS(CREDITS)
	) i_cic_decim_top (
		.clock(clock),
		.rst_i(rst_i),
		.in_strobe_i(in_strobe_i),
		.in_i_i(in_i_i),
		.in_q_i(in_q_i),
		.credit_i(credit_i),
		.out_valid_o(out_valid_o),
		.out_sample_o(out_sample_o),
		.overflow_o(overflow_o)
	);

	bind credit_fifo cic_decim_chk #(
		.CREDITS(CREDITS),
		.CRD_W(CRD_W)
	) i_cic_decim_chk (
		.clock(clock),
		.rst_i(rst_i),
		.out_valid_i(out_valid_o),
		.credits_i(credits)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ------------------------------
	// reference model
	// ------------------------------

	// keep top OUT_W bits, add the bit below
	function automatic logic [OUT_W-1:0] round_acc(input logic [63:0] v);
		logic [63:0] top;
		logic [63:0] below;
		top = (v >> (ACC_W - OUT_W)) & OUT_MASK;
		below = (v >> (ACC_W - OUT_W - 1)) & 64'd1;
		return OUT_W'(top + below);
	endfunction

	// integrators every input, combs every DECIMATION-th
	function automatic void model_input(input logic signed [IN_WIDTH-1:0] x_i,
		input logic signed [IN_WIDTH-1:0] x_q);
		logic [63:0] add;
		logic [63:0] c;
		logic [63:0] d;
		cic_pkg::cic_sample_t s;
		for (int ch = 0; ch < 2; ch++)
		begin
			add = ((ch == 0) ? 64'(x_i) : 64'(x_q)) & ACC_MASK;
			for (int k = 0; k < STAGES; k++)
			begin
				integ_st[ch][k] = (integ_st[ch][k] + add) & ACC_MASK;
				add = integ_st[ch][k];
			end
		end
		phase_cnt++;
		if (phase_cnt == DECIMATION)
		begin
			phase_cnt = 0;
			for (int ch = 0; ch < 2; ch++)
			begin
				c = integ_st[ch][STAGES-1];
				// differential delay 1, prev starts at zero
				for (int k = 0; k < STAGES; k++)
				begin
					d = (c - prev_st[ch][k]) & ACC_MASK;
					prev_st[ch][k] = c;
					c = d;
				end
				s.data = round_acc(c);
				s.is_q = (ch == 1);
				exp_q.push_back(s);
			end
		end
	endfunction

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	// one strobe, then idle to a 4 cycle spacing
	task automatic drive_input(input logic signed [IN_WIDTH-1:0] x_i,
		input logic signed [IN_WIDTH-1:0] x_q);
		@(posedge clock);
		in_strobe_i <= 1'b1;
		in_i_i <= x_i;
		in_q_i <= x_q;
		model_input(x_i, x_q);
		@(posedge clock);
		in_strobe_i <= 1'b0;
		repeat (2) @(posedge clock);
	endtask

	task automatic repeat_input(input int count, input logic signed [IN_WIDTH-1:0] x_i,
		input logic signed [IN_WIDTH-1:0] x_q);
		for (int n = 0; n < count; n++)
			drive_input(x_i, x_q);
	endtask

	// random q, i random or zero
	task automatic feed_random(input int count, input logic i_is_zero);
		logic signed [IN_WIDTH-1:0] xi;
		logic signed [IN_WIDTH-1:0] xq;
		for (int n = 0; n < count; n++)
		begin
			xi = i_is_zero ? '0 : IN_WIDTH'($urandom);
			xq = IN_WIDTH'($urandom);
			drive_input(xi, xq);
		end
	endtask

	task automatic wait_drained(input string what);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT)
		begin
			@(posedge clock);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			timeouts++;
			$display("timeout in %s: %0d expected samples never arrived", what, exp_q.size());
		end
	endtask

	// ------------------------------
	// consumer and compare
	// ------------------------------

	// each received sample gives its credit back after a random delay
	always @(posedge clock)
	begin
		if (rst_i)
		begin
			owed = 0;
			delay = 0;
			credit_i <= 1'b0;
		end
		else
		begin
			credit_i <= 1'b0;
			if (out_valid_o)
				owed++;
			if (delay > 0)
				delay--;
			else if (owed > 0 && !hold_credits)
			begin
				credit_i <= 1'b1;
				owed--;
				delay = $urandom_range(5, 0);
			end
		end
	end

	always @(posedge clock)
	begin
		if (!rst_i && out_valid_o)
		begin
			if (hold_credits)
				held_sends++;
			if (check_en)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					$display("output sample at time %0t with none expected", $time);
					data_errors++;
				end
				if (exp_q.size() != 0)
				begin
					expected = exp_q.pop_front();
					assert (out_sample_o == expected)
					else
					begin
						$display("** Error at %0t: got data %0d is_q %0b, expected data %0d is_q %0b",
							$time, out_sample_o.data, out_sample_o.is_q,
							expected.data, expected.is_q);
						data_errors++;
					end
					if (!out_sample_o.is_q)
						last_i = out_sample_o.data;
					// i channel silent in this phase
					if (zero_i && !out_sample_o.is_q)
						assert (out_sample_o.data == '0)
						else
						begin
							$display("** Error at %0t: i sample %0d, expected 0",
								$time, out_sample_o.data);
							data_errors++;
						end
				end
			end
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial
	begin
		int held_base;
		int n;
		int chk_fails;
		seed = 80;
		void'($urandom(seed));
		for (int ch = 0; ch < 2; ch++)
			for (int k = 0; k < STAGES; k++)
			begin
				integ_st[ch][k] = '0;
				prev_st[ch][k] = '0;
			end
		repeat (2) @(posedge clock);
		rst_i <= 1'b0;
		@(posedge clock);
		assert (!out_valid_o && !overflow_o)
		else
		begin
			$display("** Error at %0t: after reset out_valid_o %0b overflow_o %0b, expected 0",
				$time, out_valid_o, overflow_o);
			check_errors++;
		end

		// impulse, silence, then a step that settles to STEP
		drive_input(FULL_SCALE, '0);
		repeat_input(4 * DECIMATION - 1, '0, '0);
		repeat_input(6 * DECIMATION, STEP, '0);
		wait_drained("impulse and step");
		assert (last_i == STEP)
		else
		begin
			$display("** Error at %0t: settled i %0d, expected %0d", $time, last_i, STEP);
			check_errors++;
		end

		feed_random(40 * DECIMATION, 1'b0);
		wait_drained("random data");

		// flush i comb history, then zero i with random q
		feed_random(4 * DECIMATION, 1'b1);
		wait_drained("i flush");
		zero_i <= 1'b1;
		feed_random(10 * DECIMATION, 1'b1);
		wait_drained("zero i");
		zero_i <= 1'b0;

		// short credit stall, three samples reach the fifo under the hold
		hold_credits <= 1'b1;
		held_base = held_sends;
		feed_random(2 * DECIMATION + 4, 1'b0);
		hold_credits <= 1'b0;
		assert (held_sends - held_base <= CREDITS)
		else
		begin
			$display("** Error at %0t: %0d samples sent without credit return, limit %0d",
				$time, held_sends - held_base, CREDITS);
			check_errors++;
		end
		feed_random(2 * DECIMATION, 1'b0);
		wait_drained("credit back-pressure");
		assert (!overflow_o)
		else
		begin
			$display("** Error at %0t: overflow_o 1 after a short stall, expected 0", $time);
			check_errors++;
		end

		// long stall, samples get dropped
		check_en <= 1'b0;
		hold_credits <= 1'b1;
		feed_random(4 * DECIMATION, 1'b0);
		n = 0;
		while (!overflow_o && n < WAIT_LIMIT)
		begin
			@(posedge clock);
			n++;
		end
		if (!overflow_o)
		begin
			timeouts++;
			$display("timeout waiting for overflow_o during the long credit stall");
		end
		hold_credits <= 1'b0;
		for (int c = 0; c < 40; c++)
		begin
			@(posedge clock);
			assert (overflow_o)
			else
			begin
				$display("** Error at %0t: overflow_o cleared before reset", $time);
				check_errors++;
			end
		end
		rst_i <= 1'b1;
		repeat (2) @(posedge clock);
		rst_i <= 1'b0;
		@(posedge clock);
		assert (!overflow_o && !out_valid_o)
		else
		begin
			$display("** Error at %0t: overflow_o %0b out_valid_o %0b after reset, expected 0",
				$time, overflow_o, out_valid_o);
			check_errors++;
		end

		chk_fails = i_cic_decim_top.i_credit_fifo.i_cic_decim_chk.fail_count;
		$display("errors: data %0d, checks %0d, assertions %0d, timeouts %0d",
			data_errors, check_errors, chk_fails, timeouts);
		if (data_errors + check_errors + chk_fails + timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
